/* mips_datapath.f */
common/mips_pkg.sv
common/pipe_if.sv
decode/instr_decoder.sv
logic/reg_file.sv
execute/execute_stage.sv
logic/data_ram.sv
logic/result_stage.sv
logic/mips_datapath.sv
testbench/tb_mips_datapath.sv

/* testbench/tb_mips_datapath.sv */
//====================================================================
// MIPS datapath testbench with an instruction table of expected
// retire values and a random addiu / xori phase
//====================================================================
module tb_mips_datapath;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int RAND_N = 24;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
        logic [31:0] npc;
        logic        ovf;
    } retire_t;

    logic        i_clk;
    logic        i_reset;
    logic        i_valid;
    logic [31:0] i_instr;
    logic [31:0] i_pc;
    logic        o_valid;
    logic        o_wb_we;
    logic [4:0]  o_wb_addr;
    logic [31:0] o_wb_data;
    logic [31:0] o_next_pc;
    logic        o_ovf;

    int          cycle = 0;
    int          cycle_limit = 1000;
    int          errors = 0;
    logic [31:0] row_pc;
    logic [31:0] tbl_instr [$];    // Stimulus table
    logic [31:0] tbl_pc [$];
    retire_t     tbl_exp [$];
    int          tbl_gap [$];      // Cycles to the next strobe
    retire_t     exp_q [$];        // Instructions in flight
    int          due_q [$];
    retire_t     head;
    logic [31:0] shadow [8];       // Register model of the random phase

    mips_datapath u_dut (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid),
        .i_instr(i_instr), .i_pc(i_pc),
        .o_valid(o_valid), .o_wb_we(o_wb_we), .o_wb_addr(o_wb_addr),
        .o_wb_data(o_wb_data), .o_next_pc(o_next_pc), .o_ovf(o_ovf)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) cycle <= cycle + 1;

    always @(posedge i_clk) begin
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d instructions never retired",
                     cycle, due_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ==================================================================
    // Encoders, model and table
    // ==================================================================
    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                          input int sh, input logic [5:0] fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // xori zero extends, addiu sign extends
    function automatic logic [31:0] imm_result(input logic use_xori, input logic [31:0] a,
                                               input logic [15:0] imm);
        if (use_xori)
            return a ^ {16'h0000, imm};
        return a + {{16{imm[15]}}, imm};
    endfunction

    task automatic row(input logic [31:0] instr, input logic we, input int addr,
                       input logic [31:0] data, input logic [31:0] npc, input logic ovf,
                       input int gap);
        retire_t r;
        r.we   = we;
        r.addr = addr[4:0];
        r.data = data;
        r.npc  = npc;
        r.ovf  = ovf;
        tbl_instr.push_back(instr);
        tbl_pc.push_back(row_pc);
        tbl_exp.push_back(r);
        tbl_gap.push_back(gap);
        row_pc = row_pc + 4;
    endtask

    task automatic load_table();
        row_pc = 32'h0000_0100;
        // Operand setup, then add / sub with and without overflow
        row(enc_i(6'h09, 0, 1, 16'h1234), 1, 1, 32'h0000_1234, row_pc + 4, 0, 4); // addiu
        row(enc_i(6'h0f, 0, 2, 16'h7fff), 1, 2, 32'h7fff_0000, row_pc + 4, 0, 4); // lui
        row(enc_i(6'h0d, 2, 2, 16'hffff), 1, 2, 32'h7fff_ffff, row_pc + 4, 0, 4); // ori
        row(enc_i(6'h09, 0, 3, 16'hffff), 1, 3, 32'hffff_ffff, row_pc + 4, 0, 4); // addiu -1
        row(enc_r(2, 1, 4, 0, 6'h20), 1, 4, 32'h8000_1233, row_pc + 4, 1, 4);     // add
        row(enc_r(2, 1, 5, 0, 6'h21), 1, 5, 32'h8000_1233, row_pc + 4, 0, 4);     // addu
        row(enc_i(6'h08, 2, 6, 16'h0001), 1, 6, 32'h8000_0000, row_pc + 4, 1, 4); // addi
        row(enc_i(6'h09, 2, 6, 16'h0001), 1, 6, 32'h8000_0000, row_pc + 4, 0, 4); // addiu
        row(enc_r(6, 1, 7, 0, 6'h22), 1, 7, 32'h7fff_edcc, row_pc + 4, 1, 4);     // sub
        row(enc_r(6, 1, 7, 0, 6'h23), 1, 7, 32'h7fff_edcc, row_pc + 4, 0, 4);     // subu
        // Logic and compare
        row(enc_r(3, 1, 8, 0, 6'h24), 1, 8, 32'h0000_1234, row_pc + 4, 0, 4);     // and
        row(enc_r(2, 1, 8, 0, 6'h26), 1, 8, 32'h7fff_edcb, row_pc + 4, 0, 4);     // xor
        row(enc_r(1, 0, 9, 0, 6'h27), 1, 9, 32'hffff_edcb, row_pc + 4, 0, 4);     // nor
        row(enc_r(3, 1, 10, 0, 6'h2a), 1, 10, 32'h0000_0001, row_pc + 4, 0, 4);   // slt
        row(enc_r(3, 1, 10, 0, 6'h2b), 1, 10, 32'h0000_0000, row_pc + 4, 0, 4);   // sltu
        row(enc_i(6'h0a, 3, 11, 16'h0000), 1, 11, 32'h0000_0001, row_pc + 4, 0, 4); // slti
        row(enc_i(6'h0b, 2, 11, 16'hffff), 1, 11, 32'h0000_0001, row_pc + 4, 0, 4); // sltiu
        row(enc_i(6'h0c, 3, 12, 16'h8001), 1, 12, 32'h0000_8001, row_pc + 4, 0, 4); // andi
        row(enc_i(6'h0e, 1, 12, 16'hffff), 1, 12, 32'h0000_edcb, row_pc + 4, 0, 4); // xori
        // r0 write is reported but r0 still reads zero
        row(enc_i(6'h09, 0, 0, 16'h0005), 1, 0, 32'h0000_0005, row_pc + 4, 0, 4);
        row(enc_r(0, 1, 13, 0, 6'h21), 1, 13, 32'h0000_1234, row_pc + 4, 0, 4);
        // Shifts
        row(enc_r(0, 1, 14, 4, 6'h00), 1, 14, 32'h0001_2340, row_pc + 4, 0, 4);   // sll
        row(enc_r(0, 6, 14, 8, 6'h02), 1, 14, 32'h0080_0000, row_pc + 4, 0, 4);   // srl
        row(enc_r(0, 6, 14, 8, 6'h03), 1, 14, 32'hff80_0000, row_pc + 4, 0, 4);   // sra
        // Store then load
        row(enc_i(6'h2b, 0, 2, 16'h0020), 0, 0, 32'h0, row_pc + 4, 0, 4);         // sw
        row(enc_i(6'h23, 0, 15, 16'h0020), 1, 15, 32'h7fff_ffff, row_pc + 4, 0, 4); // lw
        row(enc_i(6'h23, 0, 16, 16'h0024), 1, 16, 32'h0000_0000, row_pc + 4, 0, 4); // lw
        // Branches
        row(enc_i(6'h04, 1, 13, 16'h0003), 0, 0, 32'h0, row_pc + 16, 0, 4);       // beq taken
        row(enc_i(6'h04, 1, 0, 16'h0003), 0, 0, 32'h0, row_pc + 4, 0, 4);         // beq not
        row(enc_i(6'h05, 1, 0, 16'hfffe), 0, 0, 32'h0, row_pc - 4, 0, 4);         // bne back
        row(enc_i(6'h06, 3, 0, 16'h0005), 0, 0, 32'h0, row_pc + 24, 0, 4);        // blez
        row(enc_i(6'h07, 3, 0, 16'h0005), 0, 0, 32'h0, row_pc + 4, 0, 4);         // bgtz not
        row(enc_i(6'h07, 1, 0, 16'h0005), 0, 0, 32'h0, row_pc + 24, 0, 4);        // bgtz
        row(enc_i(6'h01, 3, 0, 16'h0002), 0, 0, 32'h0, row_pc + 12, 0, 4);        // bltz
        row(enc_i(6'h01, 3, 1, 16'h0002), 0, 0, 32'h0, row_pc + 4, 0, 4);         // bgez not
        // Jumps keep the upper nibble of pc+4
        row_pc = 32'h2fff_fffc;
        row(enc_j(6'h02, 26'h000_0040), 0, 0, 32'h0, 32'h3000_0100, 0, 4);        // j
        row_pc = 32'h0000_0200;
        row(enc_j(6'h03, 26'h012_3456), 1, 31, row_pc + 8, 32'h0048_d158, 0, 4);  // jal
        row(enc_r(1, 0, 0, 0, 6'h08), 0, 0, 32'h0, 32'h0000_1234, 0, 4);          // jr
        row(enc_r(13, 0, 31, 0, 6'h09), 1, 31, row_pc + 8, 32'h0000_1234, 0, 4);  // jalr
        row(32'h0000_0000, 0, 0, 32'h0, row_pc, 0, 4);                            // halt
        // Back-to-back group of independent instructions
        row(enc_i(6'h09, 1, 17, 16'h0001), 1, 17, 32'h0000_1235, row_pc + 4, 0, 1);
        row(enc_i(6'h0d, 0, 18, 16'habcd), 1, 18, 32'h0000_abcd, row_pc + 4, 0, 1);
        row(enc_r(0, 3, 19, 31, 6'h00), 1, 19, 32'h8000_0000, row_pc + 4, 0, 1);
        row(enc_r(1, 3, 20, 0, 6'h2a), 1, 20, 32'h0000_0000, row_pc + 4, 0, 4);
    endtask

    // ==================================================================
    // Drive and check
    // ==================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s: got %h, expected %h in cycle %0d", name, got, expected, cycle);
            errors++;
        end
    endtask

    task automatic strobe(input logic [31:0] instr, input logic [31:0] pc, input retire_t r);
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_instr <= instr;
        i_pc    <= pc;
        exp_q.push_back(r);
        due_q.push_back(cycle + 4);   // Retire cycle as seen at the falling edge
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge i_clk);
            i_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        while (due_q.size() != 0) @(posedge i_clk);
    endtask

    // Retire check against the oldest instruction in flight
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (o_valid) begin
                if (due_q.size() == 0 || due_q[0] != cycle) begin
                    $display("Unexpected retire in cycle %0d", cycle);
                    errors++;
                end else begin
                    head = exp_q[0];
                    check_value("o_wb_we", o_wb_we, head.we);
                    if (head.we) begin
                        check_value("o_wb_addr", o_wb_addr, head.addr);
                        check_value("o_wb_data", o_wb_data, head.data);
                    end
                    check_value("o_next_pc", o_next_pc, head.npc);
                    check_value("o_ovf", o_ovf, head.ovf);
                end
            end else if (due_q.size() != 0 && due_q[0] == cycle) begin
                $display("Instruction due in cycle %0d did not retire", cycle);
                errors++;
            end
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] result;
        logic [15:0] imm;
        logic        use_xori;
        int          rs;
        int          rt;
        retire_t     r;

        i_clk   = 1'b0;
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_instr = '0;
        i_pc    = '0;
        rnd     = 32'd32;
        load_table();
        cycle_limit = 4 * (tbl_instr.size() + RAND_N) + 20;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;

        for (int i = 0; i < tbl_instr.size(); i++) begin
            strobe(tbl_instr[i], tbl_pc[i], tbl_exp[i]);
            idle(tbl_gap[i] - 1);
        end
        drain();

        // Random phase on cleared registers
        @(posedge i_clk);
        i_reset <= 1'b1;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;
        for (int k = 0; k < 8; k++) shadow[k] = '0;
        for (int i = 0; i < RAND_N; i++) begin
            rnd      = lcg_next(rnd);
            imm      = rnd[31:16];
            rnd      = lcg_next(rnd);
            use_xori = rnd[31];
            rs       = rnd[30:28];
            rt       = 1 + rnd[27:25] % 7;
            result   = imm_result(use_xori, shadow[rs], imm);
            shadow[rt] = result;
            r.we   = 1'b1;
            r.addr = rt[4:0];
            r.data = result;
            r.npc  = 32'h0000_2000 + 4 * i + 4;
            r.ovf  = 1'b0;
            strobe(enc_i(use_xori ? 6'h0e : 6'h09, rs, rt, imm), 32'h0000_2000 + 4 * i, r);
            idle(3);
        end
        drain();

        $display("Run finished after %0d cycles with %0d errors", cycle, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* logic/mips_datapath.sv */
//====================================================================
// Top level of the three-stage MIPS datapath
//====================================================================
module mips_datapath (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_valid,
    input  mips_pkg::word_t    i_instr,
    input  mips_pkg::word_t    i_pc,
    output logic               o_valid,
    output logic               o_wb_we,
    output mips_pkg::reg_idx_t o_wb_addr,
    output mips_pkg::word_t    o_wb_data,
    output mips_pkg::word_t    o_next_pc,
    output logic               o_ovf
);
    import mips_pkg::*;

    reg_idx_t rs_addr;
    reg_idx_t rt_addr;
    word_t    rs_val;
    word_t    rt_val;
    logic     rf_we;
    reg_idx_t rf_addr;
    word_t    rf_data;
    logic     ram_we;
    word_t    ram_addr;
    word_t    ram_wdata;
    word_t    ram_rdata;

    dx_if u_dx ();
    xr_if u_xr ();

    instr_decoder u_decode (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid),
        .i_instr(i_instr), .i_pc(i_pc),
        .i_rs_val(rs_val), .i_rt_val(rt_val),
        .o_rs_addr(rs_addr), .o_rt_addr(rt_addr),
        .dx(u_dx.src)
    );

    reg_file u_regs (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rs_addr(rs_addr), .i_rt_addr(rt_addr),
        .i_we(rf_we), .i_wr_addr(rf_addr), .i_wr_data(rf_data),
        .o_rs_val(rs_val), .o_rt_val(rt_val)
    );

    execute_stage u_exec (
        .i_clk(i_clk), .i_reset(i_reset),
        .dx(u_dx.dst), .xr(u_xr.src)
    );

    data_ram u_ram (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_we(ram_we), .i_addr(ram_addr), .i_wdata(ram_wdata),
        .o_rdata(ram_rdata)
    );

    result_stage u_result (
        .i_clk(i_clk), .i_reset(i_reset), .xr(u_xr.dst),
        .i_ram_rdata(ram_rdata),
        .o_ram_we(ram_we), .o_ram_addr(ram_addr), .o_ram_wdata(ram_wdata),
        .o_rf_we(rf_we), .o_rf_addr(rf_addr), .o_rf_data(rf_data),
        .o_valid(o_valid), .o_wb_we(o_wb_we), .o_wb_addr(o_wb_addr),
        .o_wb_data(o_wb_data), .o_next_pc(o_next_pc), .o_ovf(o_ovf)
    );

endmodule

/* logic/result_stage.sv */
//====================================================================
// Result stage: writeback select, store issue, retire outputs
//====================================================================
module result_stage (
    input  logic               i_clk,
    input  logic               i_reset,
    xr_if.dst                  xr,
    input  mips_pkg::word_t    i_ram_rdata,
    output logic               o_ram_we,
    output mips_pkg::word_t    o_ram_addr,
    output mips_pkg::word_t    o_ram_wdata,
    output logic               o_rf_we,
    output mips_pkg::reg_idx_t o_rf_addr,
    output mips_pkg::word_t    o_rf_data,
    output logic               o_valid,
    output logic               o_wb_we,
    output mips_pkg::reg_idx_t o_wb_addr,
    output mips_pkg::word_t    o_wb_data,
    output mips_pkg::word_t    o_next_pc,
    output logic               o_ovf
);
    import mips_pkg::*;

    always_comb begin
        case (xr.wb_sel)
            WB_MEM:   o_rf_data = i_ram_rdata;
            WB_SHIFT: o_rf_data = xr.shift_res;
            WB_LINK:  o_rf_data = xr.link;
            default:  o_rf_data = xr.alu_res;
        endcase
    end

    assign o_ram_we    = xr.valid && xr.mem_we;
    assign o_ram_addr  = xr.ea;
    assign o_ram_wdata = xr.store_data;
    assign o_rf_we     = xr.valid && xr.wr_en;
    assign o_rf_addr   = xr.dest;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_wb_we <= 1'b0;
            o_ovf   <= 1'b0;
        end else begin
            o_valid <= xr.valid;
            o_wb_we <= o_rf_we;
            o_ovf   <= xr.valid && xr.ovf;
        end
    end

    always_ff @(posedge i_clk) begin
        if (xr.valid) begin
            o_wb_addr <= o_rf_addr;
            o_wb_data <= o_rf_data;
            o_next_pc <= xr.next_pc;
        end
    end

    // Loads must come from the decoder as RAM writebacks
    a_load_wb: assert property (@(posedge i_clk) disable iff (i_reset)
        (xr.valid && xr.mem_re) |-> (xr.wr_en && xr.wb_sel == WB_MEM));

    a_we_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_we |-> o_valid);

endmodule

/* logic/data_ram.sv */
//====================================================================
// Data RAM: 64 words, async read, sync write
//====================================================================
module data_ram (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_we,
    input  mips_pkg::word_t i_addr,
    input  mips_pkg::word_t i_wdata,
    output mips_pkg::word_t o_rdata
);
    import mips_pkg::*;

    word_t mem [64];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 64; i++) mem[i] <= '0;
        end else if (i_we) begin
            mem[i_addr[7:2]] <= i_wdata;   // Word index
        end
    end

    assign o_rdata = mem[i_addr[7:2]];

    a_aligned_store: assert property (@(posedge i_clk) disable iff (i_reset)
        i_we |-> (i_addr[1:0] == 2'b00));

endmodule

/* execute/execute_stage.sv */
//====================================================================
// Execute stage: ALU, shifter, branch test, next PC, address
//====================================================================
module execute_stage (
    input logic i_clk,
    input logic i_reset,
    dx_if.dst   dx,
    xr_if.src   xr
);
    import mips_pkg::*;

    word_t b_op;
    word_t b_eff;
    word_t sum;
    word_t alu_res;
    word_t shift_res;
    word_t pc_incr;
    word_t next_pc;
    logic  sub;
    logic  ovf;
    logic  taken;
    logic  rs_zero;

    // ==================================================================
    // ALU
    // ==================================================================
    assign b_op  = dx.b_is_imm ? dx.imm : dx.rt_val;
    assign sub   = (dx.alu_fn == ALU_SUB) || (dx.alu_fn == ALU_SUBU);
    assign b_eff = sub ? ~b_op : b_op;
    assign sum   = dx.rs_val + b_eff + {31'b0, sub};
    // Signed overflow: equal operand signs, different result sign
    assign ovf   = dx.ovf_chk && (dx.rs_val[31] == b_eff[31]) && (sum[31] != dx.rs_val[31]);

    always_comb begin
        case (dx.alu_fn)
            ALU_AND:  alu_res = dx.rs_val & b_op;
            ALU_OR:   alu_res = dx.rs_val | b_op;
            ALU_XOR:  alu_res = dx.rs_val ^ b_op;
            ALU_NOR:  alu_res = ~(dx.rs_val | b_op);
            ALU_SLT:  alu_res = {31'b0, $signed(dx.rs_val) < $signed(b_op)};
            ALU_SLTU: alu_res = {31'b0, dx.rs_val < b_op};
            ALU_LUI:  alu_res = {b_op[15:0], 16'b0};
            default:  alu_res = sum;   // add, addu, sub, subu
        endcase
    end

    always_comb begin
        case (dx.shift_fn)
            SH_SLL:  shift_res = dx.rt_val << dx.shamt;
            SH_SRL:  shift_res = dx.rt_val >> dx.shamt;
            default: shift_res = $signed(dx.rt_val) >>> dx.shamt;   // Sign fill
        endcase
    end

    // ==================================================================
    // Branch condition and next PC
    // ==================================================================
    assign rs_zero = (dx.rs_val == '0);
    assign pc_incr = dx.pc + 32'd4;

    always_comb begin
        case (dx.br_fn)
            BR_EQ:   taken = (dx.rs_val == dx.rt_val);
            BR_NE:   taken = (dx.rs_val != dx.rt_val);
            BR_LEZ:  taken = dx.rs_val[31] || rs_zero;
            BR_GTZ:  taken = !dx.rs_val[31] && !rs_zero;
            BR_LTZ:  taken = dx.rs_val[31];
            default: taken = !dx.rs_val[31];   // bgez
        endcase
    end

    always_comb begin
        case (dx.pc_sel)
            PC_BRANCH: next_pc = taken ? pc_incr + {dx.imm[29:0], 2'b00} : pc_incr;
            PC_JUMP:   next_pc = {pc_incr[31:28], dx.jindex, 2'b00};
            PC_REG:    next_pc = dx.rs_val;
            default:   next_pc = pc_incr;
        endcase
        if (dx.halt) next_pc = dx.pc;   // Halt spins in place
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) xr.valid <= 1'b0;
        else         xr.valid <= dx.valid;
    end

    always_ff @(posedge i_clk) begin
        if (dx.valid) begin
            xr.alu_res    <= alu_res;
            xr.shift_res  <= shift_res;
            xr.link       <= dx.pc + 32'd8;   // Past the delay slot
            xr.ea         <= dx.rs_val + dx.imm;
            xr.store_data <= dx.rt_val;
            xr.next_pc    <= next_pc;
            xr.dest       <= dx.dest;
            xr.wr_en      <= dx.wr_en;
            xr.wb_sel     <= dx.wb_sel;
            xr.mem_we     <= dx.mem_we;
            xr.mem_re     <= dx.mem_re;
            xr.ovf        <= ovf;
        end
    end

    a_one_mem_op: assert property (@(posedge i_clk) disable iff (i_reset)
        dx.valid |-> !(dx.mem_we && dx.mem_re));

endmodule

/* logic/reg_file.sv */
//====================================================================
// Register file: 32 x 32, two async reads, one sync write
//====================================================================
module reg_file (
    input  logic               i_clk,
    input  logic               i_reset,
    input  mips_pkg::reg_idx_t i_rs_addr,
    input  mips_pkg::reg_idx_t i_rt_addr,
    input  logic               i_we,
    input  mips_pkg::reg_idx_t i_wr_addr,
    input  mips_pkg::word_t    i_wr_data,
    output mips_pkg::word_t    o_rs_val,
    output mips_pkg::word_t    o_rt_val
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (i_we && i_wr_addr != '0) begin   // r0 stays zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs_val = regs[i_rs_addr];
    assign o_rt_val = regs[i_rt_addr];

    a_r0_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rs_addr == '0) |-> (o_rs_val == '0));

endmodule

/* decode/instr_decoder.sv */
//====================================================================
// Decode stage: field split, control generation, operand register
//====================================================================
module instr_decoder (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_valid,
    input  mips_pkg::word_t   i_instr,
    input  mips_pkg::word_t   i_pc,
    input  mips_pkg::word_t   i_rs_val,
    input  mips_pkg::word_t   i_rt_val,
    output mips_pkg::reg_idx_t o_rs_addr,
    output mips_pkg::reg_idx_t o_rt_addr,
    dx_if.src                 dx
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rd;
    logic       halt;
    logic       zext;
    alu_fn_t    alu_fn;
    wb_sel_t    wb_sel;
    pc_sel_t    pc_sel;
    br_fn_t     br_fn;
    reg_idx_t   dest;
    logic       wr_en;
    logic       mem_we;
    logic       mem_re;
    word_t      imm;

    assign opcode    = i_instr[31:26];
    assign funct     = i_instr[5:0];
    assign rd        = i_instr[15:11];
    assign o_rs_addr = i_instr[25:21];
    assign o_rt_addr = i_instr[20:16];
    assign halt      = (i_instr == '0);

    // Logical immediates are zero extended, all others sign extended
    assign imm = zext ? {16'b0, i_instr[15:0]} : {{16{i_instr[15]}}, i_instr[15:0]};

    always_comb begin
        alu_fn = ALU_ADDU;
        wb_sel = WB_ALU;
        pc_sel = PC_INCR;
        br_fn  = BR_EQ;
        dest   = o_rt_addr;   // I-type target
        wr_en  = 1'b0;
        mem_we = 1'b0;
        mem_re = 1'b0;
        zext   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dest  = rd;
                wr_en = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                    FN_NOR, FN_SLT, FN_SLTU: alu_fn = funct[3:0];
                    FN_SLL, FN_SRL, FN_SRA:  wb_sel = WB_SHIFT;
                    FN_JR: begin
                        pc_sel = PC_REG;
                        wr_en  = 1'b0;
                    end
                    FN_JALR: begin
                        pc_sel = PC_REG;
                        wb_sel = WB_LINK;
                        dest   = REG_RA;
                    end
                    default: wr_en = 1'b0;   // Unsupported function
                endcase
            end
            OP_REGIMM: begin
                pc_sel = PC_BRANCH;
                br_fn  = {2'b00, i_instr[16]};   // bltz / bgez
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                pc_sel = PC_BRANCH;
                br_fn  = opcode[2:0];
            end
            OP_J:   pc_sel = PC_JUMP;
            OP_JAL: begin
                pc_sel = PC_JUMP;
                wb_sel = WB_LINK;
                dest   = REG_RA;
                wr_en  = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                alu_fn = (opcode[2:1] == 2'b01) ? {2'b10, opcode[1:0]} :
                         (opcode[2:0] == 3'b111) ? ALU_LUI : {1'b0, opcode[2:0]};
                zext   = (opcode[2] && !(opcode[1] && opcode[0]));
                wr_en  = 1'b1;
            end
            OP_LW: begin
                wb_sel = WB_MEM;
                mem_re = 1'b1;
                wr_en  = 1'b1;
            end
            OP_SW:   mem_we = 1'b1;
            default: ;
        endcase
        if (halt) wr_en = 1'b0;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) dx.valid <= 1'b0;
        else         dx.valid <= i_valid;
    end

    // Payload captured on the strobe only
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            dx.pc       <= i_pc;
            dx.rs_val   <= i_rs_val;
            dx.rt_val   <= i_rt_val;
            dx.imm      <= imm;
            dx.shamt    <= i_instr[10:6];
            dx.jindex   <= i_instr[25:0];
            dx.alu_fn   <= alu_fn;
            dx.shift_fn <= funct[1:0];
            dx.b_is_imm <= (opcode != OP_RTYPE);
            dx.wb_sel   <= wb_sel;
            dx.pc_sel   <= pc_sel;
            dx.br_fn    <= br_fn;
            dx.dest     <= dest;
            dx.wr_en    <= wr_en;
            dx.mem_we   <= mem_we;
            dx.mem_re   <= mem_re;
            dx.halt     <= halt;
            dx.ovf_chk  <= (alu_fn == ALU_ADD) || (alu_fn == ALU_SUB);
        end
    end

    // Register file must return known operands for the strobed addresses
    a_operands_known: assert property (@(posedge i_clk) disable iff (i_reset)
        i_valid |-> !$isunknown({o_rs_addr, o_rt_addr, i_rs_val, i_rt_val}));

endmodule

/* common/pipe_if.sv */
//====================================================================
// Stage interfaces: decode to execute, execute to result
//====================================================================
interface dx_if;
    import mips_pkg::*;

    logic        valid;
    word_t       pc;
    word_t       rs_val;
    word_t       rt_val;
    word_t       imm;          // Extended immediate
    logic [4:0]  shamt;
    logic [25:0] jindex;
    alu_fn_t     alu_fn;
    shift_fn_t   shift_fn;
    logic        b_is_imm;
    wb_sel_t     wb_sel;
    pc_sel_t     pc_sel;
    br_fn_t      br_fn;
    reg_idx_t    dest;
    logic        wr_en;
    logic        mem_we;
    logic        mem_re;
    logic        halt;
    logic        ovf_chk;

    modport src (output valid, pc, rs_val, rt_val, imm, shamt, jindex, alu_fn,
                 shift_fn, b_is_imm, wb_sel, pc_sel, br_fn, dest, wr_en,
                 mem_we, mem_re, halt, ovf_chk);
    modport dst (input valid, pc, rs_val, rt_val, imm, shamt, jindex, alu_fn,
                 shift_fn, b_is_imm, wb_sel, pc_sel, br_fn, dest, wr_en,
                 mem_we, mem_re, halt, ovf_chk);
endinterface

interface xr_if;
    import mips_pkg::*;

    logic     valid;
    word_t    alu_res;
    word_t    shift_res;
    word_t    link;
    word_t    ea;
    word_t    store_data;
    word_t    next_pc;
    reg_idx_t dest;
    logic     wr_en;
    wb_sel_t  wb_sel;
    logic     mem_we;
    logic     mem_re;
    logic     ovf;

    modport src (output valid, alu_res, shift_res, link, ea, store_data,
                 next_pc, dest, wr_en, wb_sel, mem_we, mem_re, ovf);
    modport dst (input valid, alu_res, shift_res, link, ea, store_data,
                 next_pc, dest, wr_en, wb_sel, mem_we, mem_re, ovf);
endinterface

/* common/mips_pkg.sv */
//====================================================================
// Shared types of the MIPS datapath: word, register index,
// control-field selectors, opcode and function codes
//====================================================================
package mips_pkg;

    typedef logic [31:0] word_t;    // Data, address and instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_fn_t;
    typedef logic [1:0]  shift_fn_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [1:0]  pc_sel_t;
    typedef logic [2:0]  br_fn_t;

    // ALU codes follow the low four bits of the R-type function field
    localparam alu_fn_t ALU_ADD  = 4'b0000;
    localparam alu_fn_t ALU_ADDU = 4'b0001;
    localparam alu_fn_t ALU_SUB  = 4'b0010;
    localparam alu_fn_t ALU_SUBU = 4'b0011;
    localparam alu_fn_t ALU_AND  = 4'b0100;
    localparam alu_fn_t ALU_OR   = 4'b0101;
    localparam alu_fn_t ALU_XOR  = 4'b0110;
    localparam alu_fn_t ALU_NOR  = 4'b0111;
    localparam alu_fn_t ALU_SLT  = 4'b1010;
    localparam alu_fn_t ALU_SLTU = 4'b1011;
    localparam alu_fn_t ALU_LUI  = 4'b1111;

    localparam shift_fn_t SH_SLL = 2'b00;  // Same as funct[1:0]
    localparam shift_fn_t SH_SRL = 2'b10;
    localparam shift_fn_t SH_SRA = 2'b11;

    localparam wb_sel_t WB_ALU   = 2'b00;
    localparam wb_sel_t WB_MEM   = 2'b01;
    localparam wb_sel_t WB_SHIFT = 2'b10;
    localparam wb_sel_t WB_LINK  = 2'b11;

    localparam pc_sel_t PC_INCR   = 2'b00;
    localparam pc_sel_t PC_BRANCH = 2'b01;
    localparam pc_sel_t PC_JUMP   = 2'b10;
    localparam pc_sel_t PC_REG    = 2'b11;

    // Branch codes match opcode[2:0] and {2'b00, rt[0]} of REGIMM
    localparam br_fn_t BR_LTZ = 3'b000;
    localparam br_fn_t BR_GEZ = 3'b001;
    localparam br_fn_t BR_EQ  = 3'b100;
    localparam br_fn_t BR_NE  = 3'b101;
    localparam br_fn_t BR_LEZ = 3'b110;
    localparam br_fn_t BR_GTZ = 3'b111;

    localparam reg_idx_t REG_RA = 5'd31;   // Link register

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000, OP_REGIMM = 6'b000001;
    localparam logic [5:0] OP_J     = 6'b000010, OP_JAL    = 6'b000011;
    localparam logic [5:0] OP_BEQ   = 6'b000100, OP_BNE    = 6'b000101;
    localparam logic [5:0] OP_BLEZ  = 6'b000110, OP_BGTZ   = 6'b000111;
    localparam logic [5:0] OP_ADDI  = 6'b001000, OP_ADDIU  = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010, OP_SLTIU  = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100, OP_ORI    = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110, OP_LUI    = 6'b001111;
    localparam logic [5:0] OP_LW    = 6'b100011, OP_SW     = 6'b101011;

    // R-type function codes
    localparam logic [5:0] FN_SLL  = 6'b000000, FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011, FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001, FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001, FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011, FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101, FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111, FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

endpackage
